/* hw/vid_bar_pattern.sv */
`timescale 1ns/1ps
`include "vid_defs.svh"

module vid_bar_pattern (
	input  logic                  clk50m_bufg,
	input  logic                  serdes_rst,
	input  logic [`VID_CNT_W-1:0] hcount,
	input  logic                  hblnk,
	input  logic                  vblnk,
	input  vid_pkg::vid_timing_t  timing,
	output vid_pkg::vid_rgb_t     rgb
);

	logic [`VID_CNT_W-1:0] bar_pos;  // Pixel within the current bar
	logic [2:0]            bar_idx;  // 0 is the leftmost bar
	logic                  active_q;
	logic [2:0]            bar_code;

	////////////////////////////////////////
	// Stage one, bar tracking
	////////////////////////////////////////

	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			bar_pos  <= '0;
			bar_idx  <= '0;
			active_q <= 1'b0;
		end else begin
			active_q <= !hblnk && !vblnk;
			if (hcount == '0) begin // New line
				bar_pos <= '0;
				bar_idx <= '0;
			end else if (bar_pos == timing.bar_width - 1'b1) begin
				bar_pos <= '0;
				if (bar_idx != 3'd7) begin
					bar_idx <= bar_idx + 1'b1; // Holds on the last bar
				end
			end else begin
				bar_pos <= bar_pos + 1'b1;
			end
		end
	end

	assign bar_code = 3'd7 - bar_idx; // White first, black last

	// Stage two, colour out, zero in blanking
	// Green on bit 2, red bit 1, blue bit 0 gives the SMPTE order
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			rgb <= '0;
		end else if (active_q) begin
			rgb.g <= {8{bar_code[2]}};
			rgb.r <= {8{bar_code[1]}};
			rgb.b <= {8{bar_code[0]}};
		end else begin
			rgb <= '0;
		end
	end

endmodule

/* hw/vid_defs.svh */
`ifndef VID_DEFS_SVH
`define VID_DEFS_SVH

// Counter and compare width
`define VID_CNT_W 11
`define VID_FRAME_W 16 // Frame counter in STATUS[31:16]

// APB bus
`define VID_APB_AW 4
`define VID_APB_DW 32
`define VID_REG_MODE 0
`define VID_REG_STATUS 4

// Mode codes, same as the board switch settings
`define VID_MODE_VGA 4'b0000
`define VID_MODE_SVGA 4'b0001
`define VID_MODE_HDTV720P 4'b0010
`define VID_MODE_XGA 4'b0011
`define VID_MODE_SXGA 4'b1000
`define VID_MODE_CAMERA 4'b1001

////////////////////////////////////////
// Per-mode raster values
////////////////////////////////////////

// 640x480 at 60 Hz
`define VID_HPIXELS_VGA 11'd640
`define VID_VLINES_VGA 11'd480
`define VID_HSYNCPW_VGA 11'd96
`define VID_VSYNCPW_VGA 11'd2
`define VID_HFNPRCH_VGA 11'd16
`define VID_VFNPRCH_VGA 11'd11
`define VID_HBKPRCH_VGA 11'd48
`define VID_VBKPRCH_VGA 11'd31

// 800x600 at 60 Hz
`define VID_HPIXELS_SVGA 11'd800
`define VID_VLINES_SVGA 11'd600
`define VID_HSYNCPW_SVGA 11'd128
`define VID_VSYNCPW_SVGA 11'd4
`define VID_HFNPRCH_SVGA 11'd40
`define VID_VFNPRCH_SVGA 11'd1
`define VID_HBKPRCH_SVGA 11'd88
`define VID_VBKPRCH_SVGA 11'd23

// 1024x768 at 60 Hz
`define VID_HPIXELS_XGA 11'd1024
`define VID_VLINES_XGA 11'd768
`define VID_HSYNCPW_XGA 11'd136
`define VID_VSYNCPW_XGA 11'd6
`define VID_HFNPRCH_XGA 11'd24
`define VID_VFNPRCH_XGA 11'd3
`define VID_HBKPRCH_XGA 11'd160
`define VID_VBKPRCH_XGA 11'd29

// 1280x720 at 60 Hz
`define VID_HPIXELS_HDTV720P 11'd1280
`define VID_VLINES_HDTV720P 11'd720
`define VID_HSYNCPW_HDTV720P 11'd40
`define VID_VSYNCPW_HDTV720P 11'd5
`define VID_HFNPRCH_HDTV720P 11'd110
`define VID_VFNPRCH_HDTV720P 11'd5
`define VID_HBKPRCH_HDTV720P 11'd220
`define VID_VBKPRCH_HDTV720P 11'd20

// 1280x1024 at 60 Hz
`define VID_HPIXELS_SXGA 11'd1280
`define VID_VLINES_SXGA 11'd1024
`define VID_HSYNCPW_SXGA 11'd112
`define VID_VSYNCPW_SXGA 11'd3
`define VID_HFNPRCH_SXGA 11'd48
`define VID_VFNPRCH_SXGA 11'd1
`define VID_HBKPRCH_SXGA 11'd248
`define VID_VBKPRCH_SXGA 11'd38

// Camera, 720p active with trimmed porches
`define VID_HPIXELS_CAMERA 11'd1280
`define VID_VLINES_CAMERA 11'd720
`define VID_HSYNCPW_CAMERA 11'd39
`define VID_VSYNCPW_CAMERA 11'd4
`define VID_HFNPRCH_CAMERA 11'd110
`define VID_VFNPRCH_CAMERA 11'd4
`define VID_HBKPRCH_CAMERA 11'd220
`define VID_VBKPRCH_CAMERA 11'd22

`endif

/* hw/vid_mode_regs.sv */
`timescale 1ns/1ps
`include "vid_defs.svh"

module vid_mode_regs (
	input  logic                   clk50m_bufg,
	input  logic                   serdes_rst,
	// APB slave
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`VID_APB_AW-1:0] paddr,
	input  logic [`VID_APB_DW-1:0] pwdata,
	output logic [`VID_APB_DW-1:0] prdata,
	output logic                   pready,
	output logic                   pslverr,
	// Raster side
	input  vid_pkg::vid_mode_e     active_mode,
	input  logic                   frame_end,
	output vid_pkg::vid_mode_e     req_mode
);

	logic                    access;     // APB access phase
	logic                    hit_mode;
	logic                    hit_status;
	logic [`VID_FRAME_W-1:0] frame_cnt;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	assign access     = psel && penable;
	assign hit_mode   = (paddr == `VID_APB_AW'(`VID_REG_MODE));
	assign hit_status = (paddr == `VID_APB_AW'(`VID_REG_STATUS));

	assign pready  = 1'b1; // Zero wait states
	assign pslverr = access && !(hit_mode || hit_status); // Unmapped address

	// Requested mode, picked up by the raster at frame end
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			req_mode <= vid_pkg::mode_720p;
		end else if (access && pwrite && hit_mode) begin
			req_mode <= vid_pkg::vid_mode_e'(pwdata[3:0]); // Odd codes fall to 720p later
		end
	end

	// Wrapping frame counter
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			frame_cnt <= '0;
		end else if (frame_end) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Read mux
	////////////////////////////////////////

	always_comb begin
		prdata = '0;
		if (!pwrite && hit_mode) begin
			prdata[3:0] = req_mode;
		end else if (!pwrite && hit_status) begin
			prdata[3:0] = active_mode; // Mode the raster runs now
			prdata[`VID_APB_DW-1 -: `VID_FRAME_W] = frame_cnt;
		end
	end

endmodule

/* hw/vid_pkg.sv */
`include "vid_defs.svh"

package vid_pkg;

	// Video mode select
	typedef enum logic [3:0] {
		mode_vga    = `VID_MODE_VGA,
		mode_svga   = `VID_MODE_SVGA,
		mode_720p   = `VID_MODE_HDTV720P,
		mode_xga    = `VID_MODE_XGA,
		mode_sxga   = `VID_MODE_SXGA,
		mode_camera = `VID_MODE_CAMERA
	} vid_mode_e;

	// Compare points of the active mode
	typedef struct packed {
		logic [`VID_CNT_W-1:0] hsblnk; // Last active pixel
		logic [`VID_CNT_W-1:0] hssync; // Hsync starts after this
		logic [`VID_CNT_W-1:0] hesync; // Last hsync pixel
		logic [`VID_CNT_W-1:0] heblnk; // Last pixel of the line
		logic [`VID_CNT_W-1:0] vsblnk;
		logic [`VID_CNT_W-1:0] vssync;
		logic [`VID_CNT_W-1:0] vesync;
		logic [`VID_CNT_W-1:0] veblnk;
		logic                  polarity;  // 1 means negative sync
		logic [`VID_CNT_W-1:0] bar_width; // Pixels per colour bar
	} vid_timing_t;

	// Pixel colour
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} vid_rgb_t;

endpackage

/* hw/vid_raster_counter.sv */
`timescale 1ns/1ps
`include "vid_defs.svh"

module vid_raster_counter (
	input  logic                   clk50m_bufg,
	input  logic                   serdes_rst,
	input  vid_pkg::vid_mode_e     req_mode,
	input  vid_pkg::vid_timing_t   timing,
	output vid_pkg::vid_mode_e     active_mode,
	output logic                   frame_end,
	output logic [`VID_CNT_W-1:0]  hcount,
	output logic                   hblnk,
	output logic                   vblnk,
	output logic                   hsync_raw,
	output logic                   vsync_raw
);

	logic [`VID_CNT_W-1:0] vcount;
	logic                  line_last;  // Last pixel of the line
	logic                  frame_last; // Last pixel of the last line

	assign line_last  = (hcount == timing.heblnk);
	assign frame_last = line_last && (vcount == timing.veblnk);

	////////////////////////////////////////
	// Counters
	////////////////////////////////////////

	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			hcount <= '0;
		end else if (line_last) begin
			hcount <= '0;
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			vcount <= '0;
		end else if (frame_last) begin
			vcount <= '0;
		end else if (line_last) begin
			vcount <= vcount + 1'b1; // Next line
		end
	end

	// Mode switch only on the frame boundary, so the new
	// timing always starts from pixel 0, line 0
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			active_mode <= vid_pkg::mode_720p;
			frame_end   <= 1'b0;
		end else begin
			frame_end <= frame_last; // One-cycle pulse per frame
			if (frame_last) begin
				active_mode <= req_mode;
			end
		end
	end

	////////////////////////////////////////
	// Raw blank and sync
	////////////////////////////////////////

	assign hblnk     = (hcount > timing.hsblnk);
	assign hsync_raw = (hcount > timing.hssync) && (hcount <= timing.hesync);
	assign vblnk     = (vcount > timing.vsblnk);
	assign vsync_raw = (vcount > timing.vssync) && (vcount <= timing.vesync);

endmodule

/* hw/vid_sync_shaper.sv */
`timescale 1ns/1ps

module vid_sync_shaper (
	input  logic                 clk50m_bufg,
	input  logic                 serdes_rst,
	input  logic                 hblnk,
	input  logic                 vblnk,
	input  logic                 hsync_raw,
	input  logic                 vsync_raw,
	input  vid_pkg::vid_timing_t timing,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 de
);

	logic hsync_q; // First stage
	logic vsync_q;
	logic active_q;

	////////////////////////////////////////
	// Polarity and stage one
	////////////////////////////////////////

	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			hsync_q  <= 1'b0;
			vsync_q  <= 1'b0;
			active_q <= 1'b0;
		end else begin
			hsync_q  <= hsync_raw ^ timing.polarity; // Idle high when negative
			vsync_q  <= vsync_raw ^ timing.polarity;
			active_q <= !hblnk && !vblnk;
		end
	end

	// Stage two, lines up with the pattern output
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			de    <= 1'b0;
		end else begin
			hsync <= hsync_q;
			vsync <= vsync_q;
			de    <= active_q;
		end
	end

endmodule

/* hw/vid_timing_table.sv */
`timescale 1ns/1ps
`include "vid_defs.svh"

module vid_timing_table (
	input  vid_pkg::vid_mode_e   active_mode,
	output vid_pkg::vid_timing_t timing
);

	// Porches and pulses stacked on top of the active size
	function automatic vid_pkg::vid_timing_t mode_timing(
		input logic [`VID_CNT_W-1:0] hpixels,
		input logic [`VID_CNT_W-1:0] vlines,
		input logic [`VID_CNT_W-1:0] hsyncpw,
		input logic [`VID_CNT_W-1:0] vsyncpw,
		input logic [`VID_CNT_W-1:0] hfnprch,
		input logic [`VID_CNT_W-1:0] vfnprch,
		input logic [`VID_CNT_W-1:0] hbkprch,
		input logic [`VID_CNT_W-1:0] vbkprch,
		input logic                  neg_sync
	);
		vid_pkg::vid_timing_t t;
		t.hsblnk    = hpixels - 1'b1;
		t.hssync    = t.hsblnk + hfnprch;
		t.hesync    = t.hssync + hsyncpw;
		t.heblnk    = t.hesync + hbkprch;
		t.vsblnk    = vlines - 1'b1;
		t.vssync    = t.vsblnk + vfnprch;
		t.vesync    = t.vssync + vsyncpw;
		t.veblnk    = t.vesync + vbkprch;
		t.polarity  = neg_sync;
		t.bar_width = hpixels >> 3; // Eight bars per line
		return t;
	endfunction

	////////////////////////////////////////
	// Mode lookup
	////////////////////////////////////////

	always_comb begin
		case (active_mode)
			vid_pkg::mode_vga: timing = mode_timing( // Negative sync
				`VID_HPIXELS_VGA, `VID_VLINES_VGA, `VID_HSYNCPW_VGA, `VID_VSYNCPW_VGA,
				`VID_HFNPRCH_VGA, `VID_VFNPRCH_VGA, `VID_HBKPRCH_VGA, `VID_VBKPRCH_VGA,
				1'b1);
			vid_pkg::mode_svga: timing = mode_timing(
				`VID_HPIXELS_SVGA, `VID_VLINES_SVGA, `VID_HSYNCPW_SVGA, `VID_VSYNCPW_SVGA,
				`VID_HFNPRCH_SVGA, `VID_VFNPRCH_SVGA, `VID_HBKPRCH_SVGA, `VID_VBKPRCH_SVGA,
				1'b0);
			vid_pkg::mode_xga: timing = mode_timing( // Negative sync
				`VID_HPIXELS_XGA, `VID_VLINES_XGA, `VID_HSYNCPW_XGA, `VID_VSYNCPW_XGA,
				`VID_HFNPRCH_XGA, `VID_VFNPRCH_XGA, `VID_HBKPRCH_XGA, `VID_VBKPRCH_XGA,
				1'b1);
			vid_pkg::mode_sxga: timing = mode_timing(
				`VID_HPIXELS_SXGA, `VID_VLINES_SXGA, `VID_HSYNCPW_SXGA, `VID_VSYNCPW_SXGA,
				`VID_HFNPRCH_SXGA, `VID_VFNPRCH_SXGA, `VID_HBKPRCH_SXGA, `VID_VBKPRCH_SXGA,
				1'b0);
			vid_pkg::mode_camera: timing = mode_timing(
				`VID_HPIXELS_CAMERA, `VID_VLINES_CAMERA,
				`VID_HSYNCPW_CAMERA, `VID_VSYNCPW_CAMERA,
				`VID_HFNPRCH_CAMERA, `VID_VFNPRCH_CAMERA,
				`VID_HBKPRCH_CAMERA, `VID_VBKPRCH_CAMERA,
				1'b0);
			default: timing = mode_timing( // 720p, also any unknown code
				`VID_HPIXELS_HDTV720P, `VID_VLINES_HDTV720P,
				`VID_HSYNCPW_HDTV720P, `VID_VSYNCPW_HDTV720P,
				`VID_HFNPRCH_HDTV720P, `VID_VFNPRCH_HDTV720P,
				`VID_HBKPRCH_HDTV720P, `VID_VBKPRCH_HDTV720P,
				1'b0);
		endcase
	end

endmodule

/* hw/vid_top.sv */
`timescale 1ns/1ps
`include "vid_defs.svh"

module vid_top (
	input  logic                   clk50m_bufg,
	input  logic                   serdes_rst,
	// APB
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`VID_APB_AW-1:0] paddr,
	input  logic [`VID_APB_DW-1:0] pwdata,
	output logic [`VID_APB_DW-1:0] prdata,
	output logic                   pready,
	output logic                   pslverr,
	// Video out
	output logic                   hsync,
	output logic                   vsync,
	output logic                   de,
	output vid_pkg::vid_rgb_t      rgb
);

	vid_pkg::vid_mode_e    req_mode;
	vid_pkg::vid_mode_e    active_mode;
	vid_pkg::vid_timing_t  timing;
	logic                  frame_end;
	logic [`VID_CNT_W-1:0] hcount;
	logic                  hblnk;
	logic                  vblnk;
	logic                  hsync_raw;
	logic                  vsync_raw;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	vid_mode_regs i_vid_mode_regs (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.active_mode (active_mode),
		.frame_end   (frame_end),
		.req_mode    (req_mode)
	);

	vid_timing_table i_vid_timing_table (
		.active_mode (active_mode),
		.timing      (timing)
	);

	////////////////////////////////////////
	// Raster and output stages
	////////////////////////////////////////

	vid_raster_counter i_vid_raster_counter (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.req_mode    (req_mode),
		.timing      (timing),
		.active_mode (active_mode),
		.frame_end   (frame_end),
		.hcount      (hcount),
		.hblnk       (hblnk),
		.vblnk       (vblnk),
		.hsync_raw   (hsync_raw),
		.vsync_raw   (vsync_raw)
	);

	vid_sync_shaper i_vid_sync_shaper (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.hblnk       (hblnk),
		.vblnk       (vblnk),
		.hsync_raw   (hsync_raw),
		.vsync_raw   (vsync_raw),
		.timing      (timing),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

	vid_bar_pattern i_vid_bar_pattern (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.hcount      (hcount),
		.hblnk       (hblnk),
		.vblnk       (vblnk),
		.timing      (timing),
		.rgb         (rgb)
	);

endmodule

/* tests/vid_assertions.sv */
`timescale 1ns/1ps
`include "vid_defs.svh"

module vid_assertions (
	input logic                   clk50m_bufg,
	input logic                   serdes_rst,
	input logic                   psel,
	input logic                   penable,
	input logic                   pwrite,
	input logic [`VID_APB_AW-1:0] paddr,
	input logic [`VID_APB_DW-1:0] prdata,
	input logic                   pready,
	input logic                   pslverr,
	input vid_pkg::vid_mode_e     active_mode,
	input logic                   hsync,
	input logic                   de,
	input vid_pkg::vid_rgb_t      rgb
);

	int unsigned           fail_count = 0; // Failed assertions so far
	logic [3:0]            mode_d1;
	logic [3:0]            mode_d2;        // Mode as seen at the shaper outputs
	logic                  hs_act;         // Hsync in its active level
	logic                  bad_addr;
	logic [`VID_CNT_W-1:0] hs_len;         // Cycles in the current hsync pulse
	logic [`VID_CNT_W-1:0] de_len;         // Cycles in the current de run

	////////////////////////////////////////
	// Mode constants
	////////////////////////////////////////

	function automatic logic [`VID_CNT_W-1:0] exp_hsync_width(input logic [3:0] mode);
		case (mode)
			`VID_MODE_VGA:    return `VID_HSYNCPW_VGA;
			`VID_MODE_SVGA:   return `VID_HSYNCPW_SVGA;
			`VID_MODE_XGA:    return `VID_HSYNCPW_XGA;
			`VID_MODE_SXGA:   return `VID_HSYNCPW_SXGA;
			`VID_MODE_CAMERA: return `VID_HSYNCPW_CAMERA;
			default:          return `VID_HSYNCPW_HDTV720P; // Unknown codes run 720p
		endcase
	endfunction

	function automatic logic [`VID_CNT_W-1:0] exp_active_width(input logic [3:0] mode);
		case (mode)
			`VID_MODE_VGA:    return `VID_HPIXELS_VGA;
			`VID_MODE_SVGA:   return `VID_HPIXELS_SVGA;
			`VID_MODE_XGA:    return `VID_HPIXELS_XGA;
			`VID_MODE_SXGA:   return `VID_HPIXELS_SXGA;
			`VID_MODE_CAMERA: return `VID_HPIXELS_CAMERA;
			default:          return `VID_HPIXELS_HDTV720P;
		endcase
	endfunction

	// VGA and XGA idle high
	function automatic logic neg_sync(input logic [3:0] mode);
		return (mode == `VID_MODE_VGA) || (mode == `VID_MODE_XGA);
	endfunction

	// Each channel either off or full scale
	function automatic logic is_bar_colour(input vid_pkg::vid_rgb_t c);
		return ((c.r == 8'h00) || (c.r == 8'hff)) &&
			((c.g == 8'h00) || (c.g == 8'hff)) &&
			((c.b == 8'h00) || (c.b == 8'hff));
	endfunction

	////////////////////////////////////////
	// Run-length tracking
	////////////////////////////////////////

	assign hs_act   = hsync ^ neg_sync(mode_d2);
	assign bad_addr = (paddr != `VID_APB_AW'(`VID_REG_MODE)) &&
		(paddr != `VID_APB_AW'(`VID_REG_STATUS));

	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			mode_d1 <= `VID_MODE_HDTV720P;
			mode_d2 <= `VID_MODE_HDTV720P;
			hs_len  <= '0;
			de_len  <= '0;
		end else begin
			mode_d1 <= active_mode; // Two stages, same lag as the shaper
			mode_d2 <= mode_d1;
			hs_len  <= hs_act ? hs_len + 1'b1 : '0;
			de_len  <= de ? de_len + 1'b1 : '0;
		end
	end

	////////////////////////////////////////
	// Video timing
	////////////////////////////////////////

	hsync_width: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
		$fell(hs_act) |-> (hs_len == exp_hsync_width(mode_d2)))
		else begin
			fail_count++;
			$error("[FAIL] %0t hsync width expected %0d got %0d", $time,
				exp_hsync_width($sampled(mode_d2)), $sampled(hs_len));
		end

	de_width: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
		$fell(de) |-> (de_len == exp_active_width(mode_d2)))
		else begin
			fail_count++;
			$error("[FAIL] %0t de width expected %0d got %0d", $time,
				exp_active_width($sampled(mode_d2)), $sampled(de_len));
		end

	// Pattern colours
	rgb_in_set: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
		de |-> is_bar_colour(rgb))
		else begin
			fail_count++;
			$error("rgb is not one of the eight bar colours while de is high");
		end

	rgb_blank: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
		!de |-> (rgb == 24'h000000))
		else begin
			fail_count++;
			$error("[FAIL] %0t rgb expected 000000 got %h", $time, $sampled(rgb));
		end

	rgb_first_white: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
		$rose(de) |-> (rgb == 24'hffffff))
		else begin
			fail_count++;
			$error("[FAIL] %0t rgb expected ffffff got %h", $time, $sampled(rgb));
		end

	////////////////////////////////////////
	// APB
	////////////////////////////////////////

	apb_ready: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
		pready)
		else begin
			fail_count++;
			$error("[FAIL] %0t pready expected 1 got %b", $time, $sampled(pready));
		end

	apb_unmapped: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
		(psel && penable && bad_addr) |-> (pslverr && (pwrite || (prdata == '0))))
		else begin
			fail_count++;
			$error("unmapped access without pslverr or with nonzero read data");
		end

	apb_no_err: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
		!(psel && penable && bad_addr) |-> !pslverr)
		else begin
			fail_count++;
			$error("[FAIL] %0t pslverr expected 0 got %b", $time, $sampled(pslverr));
		end

endmodule

/* tests/vid_tb.sv */
`timescale 1ns/1ps
`include "vid_defs.svh"

module vid_tb;

	localparam int unsigned CLK_NS = 20;

	logic                   clk50m_bufg = 1'b0;
	logic                   serdes_rst;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`VID_APB_AW-1:0] paddr;
	logic [`VID_APB_DW-1:0] pwdata;
	logic [`VID_APB_DW-1:0] prdata;
	logic                   pready;
	logic                   pslverr;
	logic                   hsync;
	logic                   vsync;
	logic                   de;
	vid_pkg::vid_rgb_t      rgb;

	int unsigned            check_errors = 0; // Readback mismatches
	int unsigned            assert_errors;
	logic [`VID_APB_DW-1:0] rd_data;
	logic                   rd_err;
	logic [15:0]            frames_a;

	always #(CLK_NS / 2) clk50m_bufg = ~clk50m_bufg; // 50 MHz

	vid_top i_vid_top (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.rgb         (rgb)
	);

	bind vid_top vid_assertions i_vid_assertions (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.active_mode (active_mode), // Internal to vid_top
		.hsync       (hsync),
		.de          (de),
		.rgb         (rgb)
	);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Total pixels per frame, blanking included
	function automatic longint unsigned frame_cycles(input logic [3:0] mode);
		longint unsigned h;
		longint unsigned v;
		case (mode)
			`VID_MODE_VGA: begin
				h = `VID_HPIXELS_VGA + `VID_HFNPRCH_VGA + `VID_HSYNCPW_VGA + `VID_HBKPRCH_VGA;
				v = `VID_VLINES_VGA + `VID_VFNPRCH_VGA + `VID_VSYNCPW_VGA + `VID_VBKPRCH_VGA;
			end
			`VID_MODE_SVGA: begin
				h = `VID_HPIXELS_SVGA + `VID_HFNPRCH_SVGA + `VID_HSYNCPW_SVGA +
					`VID_HBKPRCH_SVGA;
				v = `VID_VLINES_SVGA + `VID_VFNPRCH_SVGA + `VID_VSYNCPW_SVGA +
					`VID_VBKPRCH_SVGA;
			end
			default: begin // 720p
				h = `VID_HPIXELS_HDTV720P + `VID_HFNPRCH_HDTV720P +
					`VID_HSYNCPW_HDTV720P + `VID_HBKPRCH_HDTV720P;
				v = `VID_VLINES_HDTV720P + `VID_VFNPRCH_HDTV720P +
					`VID_VSYNCPW_HDTV720P + `VID_VBKPRCH_HDTV720P;
			end
		endcase
		return h * v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			check_errors++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	// Setup, access, release, all on falling edges
	task automatic apb_write(input logic [`VID_APB_AW-1:0] addr,
		input logic [`VID_APB_DW-1:0] data);
		@(negedge clk50m_bufg);
		psel    = 1'b1;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		penable = 1'b0;
		@(negedge clk50m_bufg);
		penable = 1'b1;
		@(negedge clk50m_bufg); // Completed on the rising edge before
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [`VID_APB_AW-1:0] addr,
		output logic [`VID_APB_DW-1:0] data, output logic err);
		@(negedge clk50m_bufg);
		psel    = 1'b1;
		pwrite  = 1'b0;
		paddr   = addr;
		penable = 1'b0;
		@(negedge clk50m_bufg);
		penable = 1'b1;
		@(negedge clk50m_bufg);
		data    = prdata; // Still in the access phase here
		err     = pslverr;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Poll STATUS until the raster runs the given mode
	task automatic wait_for_mode(input logic [3:0] mode);
		logic [`VID_APB_DW-1:0] data;
		logic                   err;
		do begin
			repeat (256) @(negedge clk50m_bufg);
			apb_read(`VID_APB_AW'(`VID_REG_STATUS), data, err);
		end while (data[3:0] !== mode);
	endtask

	task automatic wait_lines(input int unsigned n);
		repeat (n) @(posedge de);
		@(negedge clk50m_bufg);
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		serdes_rst = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		repeat (16) @(posedge clk50m_bufg);
		@(negedge clk50m_bufg);
		check_value("hsync", 32'd0, 32'(hsync)); // Reset levels, 720p idles low
		check_value("vsync", 32'd0, 32'(vsync));
		check_value("de", 32'd0, 32'(de));
		serdes_rst = 1'b0;

		apb_read(`VID_APB_AW'(`VID_REG_STATUS), rd_data, rd_err);
		check_value("STATUS mode", 32'(`VID_MODE_HDTV720P), 32'(rd_data[3:0]));
		check_value("STATUS frame count", 32'd0, 32'(rd_data[31:16]));
		apb_read(`VID_APB_AW'(`VID_REG_MODE), rd_data, rd_err);
		check_value("MODE", 32'(`VID_MODE_HDTV720P), rd_data);

		// VGA, widths checked by the bound assertions
		apb_write(`VID_APB_AW'(`VID_REG_MODE), 32'(`VID_MODE_VGA));
		apb_read(`VID_APB_AW'(`VID_REG_MODE), rd_data, rd_err);
		check_value("MODE", 32'(`VID_MODE_VGA), rd_data);
		wait_for_mode(`VID_MODE_VGA);
		wait_lines(4);

		// Frame counter across one full frame
		apb_read(`VID_APB_AW'(`VID_REG_STATUS), rd_data, rd_err);
		frames_a = rd_data[31:16];
		repeat (frame_cycles(`VID_MODE_VGA) + 64) @(negedge clk50m_bufg);
		apb_read(`VID_APB_AW'(`VID_REG_STATUS), rd_data, rd_err);
		assert (rd_data[31:16] > frames_a) else begin
			check_errors++;
			$display("[FAIL] %0t STATUS frame count expected above %0d got %0d",
				$time, frames_a, rd_data[31:16]);
		end

		// Unmapped address
		apb_read(`VID_APB_AW'(8), rd_data, rd_err);
		check_value("pslverr", 32'd1, 32'(rd_err));
		check_value("prdata", 32'd0, rd_data);
		apb_write(`VID_APB_AW'(8), 32'(`VID_MODE_SVGA)); // Must be dropped
		apb_read(`VID_APB_AW'(`VID_REG_MODE), rd_data, rd_err);
		check_value("MODE", 32'(`VID_MODE_VGA), rd_data);
		check_value("pslverr", 32'd0, 32'(rd_err));

		// SVGA
		apb_write(`VID_APB_AW'(`VID_REG_MODE), 32'(`VID_MODE_SVGA));
		wait_for_mode(`VID_MODE_SVGA);
		wait_lines(4);

		assert_errors = i_vid_top.i_vid_assertions.fail_count;
		$display("Readback errors: %0d, assertion errors: %0d", check_errors, assert_errors);
		if (check_errors == 0 && assert_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Three frames of each mode in the run, plus margin
	initial begin
		longint unsigned limit_ns;
		limit_ns = 3 * (frame_cycles(`VID_MODE_HDTV720P) + frame_cycles(`VID_MODE_VGA) +
			frame_cycles(`VID_MODE_SVGA)) * CLK_NS + 1_000_000;
		#(limit_ns);
		$display("Watchdog expired before the test sequence finished");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* vid_timing.f */
+incdir+hw
hw/vid_pkg.sv
hw/vid_mode_regs.sv
hw/vid_timing_table.sv
hw/vid_raster_counter.sv
hw/vid_sync_shaper.sv
hw/vid_bar_pattern.sv
hw/vid_top.sv
tests/vid_assertions.sv
tests/vid_tb.sv
